// File: m92_bus_pkg.sv
/*
 * M92 CPU bus bridge shared definitions
 * Bus widths, decoded board regions, the fixed CPU address map
 * and the state encoding of the SDRAM request stage.
 */

`default_nettype none

package m92_bus_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int CPU_ADDR_W = 20;
    localparam int SDR_ADDR_W = 25;
    localparam int WORD_W     = 16;
    localparam int BYTE_W     = 8;
    localparam int BANK_W     = 4;

    typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;    // CPU byte address
    typedef logic [SDR_ADDR_W-1:0] sdr_addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [BYTE_W-1:0]     byte_t;        // I/O data and port number
    typedef logic [1:0]            lane_sel_t;    // Bit 0 is the low byte
    typedef logic [BANK_W-1:0]     bank_t;

    typedef enum logic [2:0] {
        REGION_ROM,
        REGION_BANKED,
        REGION_RAM,
        REGION_VID_CTRL,
        REGION_UNMAPPED
    } region_e;

    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_WAIT,
        REQ_DONE
    } req_state_e;

    // ==============================
    // Address map
    // ==============================
    localparam cpu_addr_t ROM_END       = 20'h9FFFF;
    localparam sdr_addr_t ROM_SDR_BASE  = 25'h0000000;

    localparam cpu_addr_t BANK_START    = 20'hA0000;
    localparam cpu_addr_t BANK_END      = 20'hBFFFF;
    localparam sdr_addr_t BANK_SDR_BASE = 25'h0100000;
    localparam sdr_addr_t BANK_SIZE     = sdr_addr_t'(BANK_END - BANK_START) + 25'd1;

    localparam cpu_addr_t RAM_START     = 20'hE0000;
    localparam cpu_addr_t RAM_END       = 20'hEFFFF;
    localparam sdr_addr_t RAM_SDR_BASE  = 25'h0200000;

    localparam cpu_addr_t VID_CTRL_ADDR = 20'hF9000;

    localparam byte_t BANK_IO_PORT  = 8'h20;
    localparam word_t UNMAPPED_DATA = 16'hFFFF;    // Open bus reads high

endpackage

`default_nettype wire

// File: word_access_if.sv
/*
 * Word access link
 * Carries one aligned CPU word access from the capture stage
 * to the address decode stage. valid pulses once per access.
 */

`timescale 1ns/1ns
`default_nettype none

interface word_access_if;

    logic                   valid;
    logic                   write;
    logic                   odd;          // CPU byte address bit 0
    m92_bus_pkg::cpu_addr_t word_addr;    // Bit 0 always clear
    m92_bus_pkg::lane_sel_t lanes;
    m92_bus_pkg::word_t     wdata;        // Already steered into word lanes

    modport capture (
        output valid,
        output write,
        output odd,
        output word_addr,
        output lanes,
        output wdata
    );

    modport decode (
        input valid,
        input write,
        input odd,
        input word_addr,
        input lanes,
        input wdata
    );

endinterface

`default_nettype wire

// File: region_access_if.sv
/*
 * Region access link
 * Carries a decoded access from the decode stage to the SDRAM
 * request stage, together with the read value of local registers.
 */

`timescale 1ns/1ns
`default_nettype none

interface region_access_if;

    logic                   valid;
    logic                   write;
    logic                   odd;
    m92_bus_pkg::region_e   region;
    m92_bus_pkg::sdr_addr_t sdr_addr;
    m92_bus_pkg::lane_sel_t lanes;
    m92_bus_pkg::word_t     wdata;
    m92_bus_pkg::word_t     local_rdata;    // Video control or open bus value

    modport decode (
        output valid,
        output write,
        output odd,
        output region,
        output sdr_addr,
        output lanes,
        output wdata,
        output local_rdata
    );

    modport request (
        input valid,
        input write,
        input odd,
        input region,
        input sdr_addr,
        input lanes,
        input wdata,
        input local_rdata
    );

endinterface

`default_nettype wire

// File: bus_capture.sv
/*
 * CPU strobe capture
 * Registers single-cycle read and write strobes from the CPU and
 * turns byte addressed accesses into aligned word accesses.
 * Strobes seen while an access is in flight are dropped.
 */

`timescale 1ns/1ns
`default_nettype none

module bus_capture (
    input  wire logic                   clk_sys,
    input  wire logic                   reset_n,

    input  wire logic                   mem_read,
    input  wire logic                   mem_write,
    input  wire m92_bus_pkg::cpu_addr_t mem_addr,
    input  wire m92_bus_pkg::lane_sel_t mem_sel,
    input  wire m92_bus_pkg::word_t     mem_wdata,

    input  wire logic                   busy,

    word_access_if.capture              acc
);

    logic                   take;
    logic                   addr_odd;
    m92_bus_pkg::lane_sel_t word_lanes;
    m92_bus_pkg::word_t     word_data;

    assign take     = (mem_read | mem_write) & ~busy;
    assign addr_odd = mem_addr[0];

    // Odd byte accesses land in the upper half of the word
    always_comb begin
        if (addr_odd) begin
            word_lanes = {mem_sel[0], 1'b0};
            word_data  = {mem_wdata[7:0], 8'h00};
        end else begin
            word_lanes = mem_sel;
            word_data  = mem_wdata;
        end
    end

    // ==============================
    // Access strobe
    // ==============================
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            acc.valid <= 1'b0;
        end else begin
            acc.valid <= take;    // One pulse per accepted strobe
        end
    end

    // ==============================
    // Access payload
    // ==============================
    always_ff @(posedge clk_sys) begin
        if (take) begin
            acc.write     <= mem_write;
            acc.odd       <= addr_odd;
            acc.word_addr <= {mem_addr[19:1], 1'b0};
            acc.lanes     <= word_lanes;
            acc.wdata     <= word_data;
        end
    end

endmodule

`default_nettype wire

// File: region_decode.sv
/*
 * Board region decode
 * Classifies each word access by the fixed address map, forms the
 * SDRAM address including the banked ROM window, and keeps the
 * ROM bank register and the video control register.
 */

`timescale 1ns/1ns
`default_nettype none

module region_decode (
    input  wire logic                clk_sys,
    input  wire logic                reset_n,

    word_access_if.decode            acc,

    input  wire logic                io_write,
    input  wire m92_bus_pkg::byte_t  io_addr,
    input  wire m92_bus_pkg::byte_t  io_data,

    output m92_bus_pkg::word_t       vid_ctrl,

    region_access_if.decode          dec
);

    m92_bus_pkg::bank_t     bank;
    m92_bus_pkg::region_e   region;
    m92_bus_pkg::sdr_addr_t region_addr;
    m92_bus_pkg::sdr_addr_t bank_base;
    logic                   vid_wr;

    // Start of the selected bank inside banked ROM
    assign bank_base = m92_bus_pkg::sdr_addr_t'(bank) * m92_bus_pkg::BANK_SIZE;

    // ==============================
    // Address map
    // ==============================
    always_comb begin
        region      = m92_bus_pkg::REGION_UNMAPPED;
        region_addr = '0;
        if (acc.word_addr <= m92_bus_pkg::ROM_END) begin
            region      = m92_bus_pkg::REGION_ROM;
            region_addr = m92_bus_pkg::ROM_SDR_BASE
                        + m92_bus_pkg::sdr_addr_t'(acc.word_addr);
        end else if (acc.word_addr >= m92_bus_pkg::BANK_START &&
                     acc.word_addr <= m92_bus_pkg::BANK_END) begin
            region      = m92_bus_pkg::REGION_BANKED;
            region_addr = m92_bus_pkg::BANK_SDR_BASE + bank_base
                        + m92_bus_pkg::sdr_addr_t'(acc.word_addr - m92_bus_pkg::BANK_START);
        end else if (acc.word_addr >= m92_bus_pkg::RAM_START &&
                     acc.word_addr <= m92_bus_pkg::RAM_END) begin
            region      = m92_bus_pkg::REGION_RAM;
            region_addr = m92_bus_pkg::RAM_SDR_BASE
                        + m92_bus_pkg::sdr_addr_t'(acc.word_addr - m92_bus_pkg::RAM_START);
        end else if (acc.word_addr == m92_bus_pkg::VID_CTRL_ADDR) begin
            region      = m92_bus_pkg::REGION_VID_CTRL;
        end
    end

    assign vid_wr = acc.valid & acc.write & (region == m92_bus_pkg::REGION_VID_CTRL);

    // ==============================
    // Bank and video control registers
    // ==============================
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            bank     <= '0;
            vid_ctrl <= '0;
        end else begin
            if (io_write && io_addr == m92_bus_pkg::BANK_IO_PORT) begin
                bank <= io_data[$bits(m92_bus_pkg::bank_t)-1:0];
            end
            if (vid_wr) begin
                if (acc.lanes[0]) vid_ctrl[7:0]  <= acc.wdata[7:0];
                if (acc.lanes[1]) vid_ctrl[15:8] <= acc.wdata[15:8];
            end
        end
    end

    // Pass the decoded access on
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= acc.valid;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (acc.valid) begin
            dec.write    <= acc.write;
            dec.odd      <= acc.odd;
            dec.region   <= region;
            dec.sdr_addr <= region_addr;
            dec.lanes    <= acc.lanes;
            dec.wdata    <= acc.wdata;
            dec.local_rdata <= (region == m92_bus_pkg::REGION_VID_CTRL) ?
                               vid_ctrl : m92_bus_pkg::UNMAPPED_DATA;
        end
    end

endmodule

`default_nettype wire

// File: sdram_request.sv
/*
 * SDRAM request stage
 * Issues one SDRAM request per decoded ROM or RAM access and
 * completes local accesses directly. Holds the CPU busy while an
 * access is in flight and returns read data in CPU byte order.
 */

`timescale 1ns/1ns
`default_nettype none

module sdram_request (
    input  wire logic                  clk_sys,
    input  wire logic                  reset_n,

    region_access_if.request           dec,
    input  wire logic                  strobe,

    output m92_bus_pkg::sdr_addr_t     sdr_addr,
    output m92_bus_pkg::word_t         sdr_din,
    output m92_bus_pkg::lane_sel_t     sdr_wr_sel,
    output logic                       sdr_req,
    input  wire logic                  sdr_rdy,
    input  wire m92_bus_pkg::word_t    sdr_dout,

    output logic                       busy,
    output logic                       mem_done,
    output m92_bus_pkg::word_t         mem_rdata
);

    m92_bus_pkg::req_state_e state;
    logic                    in_flight;
    logic                    sdram_region;
    logic                    writable;
    logic                    start;
    logic                    odd_q;
    m92_bus_pkg::word_t      rdata_q;

    // Odd reads want the upper byte in the low lane
    function automatic m92_bus_pkg::word_t lane_align(input logic odd,
                                                     input m92_bus_pkg::word_t data);
        if (odd) begin
            return {8'h00, data[15:8]};
        end
        return data;
    endfunction

    assign sdram_region = (dec.region == m92_bus_pkg::REGION_ROM)    ||
                          (dec.region == m92_bus_pkg::REGION_BANKED) ||
                          (dec.region == m92_bus_pkg::REGION_RAM);
    assign writable     = (dec.region == m92_bus_pkg::REGION_RAM);
    assign start        = (state == m92_bus_pkg::REQ_IDLE) & dec.valid;

    assign busy      = in_flight;
    assign mem_done  = (state == m92_bus_pkg::REQ_DONE);
    assign mem_rdata = rdata_q;

    // ==============================
    // Request FSM
    // ==============================
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            state     <= m92_bus_pkg::REQ_IDLE;
            sdr_req   <= 1'b0;
            in_flight <= 1'b0;
        end else begin
            sdr_req <= 1'b0;

            if (strobe && !in_flight) begin
                in_flight <= 1'b1;
            end else if (state == m92_bus_pkg::REQ_DONE) begin
                in_flight <= 1'b0;    // Last busy cycle is the done cycle
            end

            case (state)
                m92_bus_pkg::REQ_IDLE: begin
                    if (dec.valid) begin
                        if (sdram_region) begin
                            sdr_req <= 1'b1;
                            state   <= m92_bus_pkg::REQ_WAIT;
                        end else begin
                            state   <= m92_bus_pkg::REQ_DONE;
                        end
                    end
                end
                m92_bus_pkg::REQ_WAIT: begin
                    if (sdr_rdy) state <= m92_bus_pkg::REQ_DONE;
                end
                m92_bus_pkg::REQ_DONE: state <= m92_bus_pkg::REQ_IDLE;
                default:               state <= m92_bus_pkg::REQ_IDLE;
            endcase
        end
    end

    // ==============================
    // Request and read data payload
    // ==============================
    always_ff @(posedge clk_sys) begin
        if (start) begin
            sdr_addr   <= dec.sdr_addr;
            sdr_din    <= dec.wdata;
            sdr_wr_sel <= (dec.write && writable) ? dec.lanes : '0;   // ROM writes read
            odd_q      <= dec.odd;
            rdata_q    <= lane_align(dec.odd, dec.local_rdata);
        end else if (state == m92_bus_pkg::REQ_WAIT && sdr_rdy) begin
            rdata_q    <= lane_align(odd_q, sdr_dout);
        end
    end

endmodule

`default_nettype wire

// File: m92_cpu_bus.sv
/*
 * M92 main CPU bus bridge
 * Capture, decode and SDRAM request stages in one pipeline.
 * The CPU is stalled while an access is in flight.
 */

`timescale 1ns/1ns
`default_nettype none

module m92_cpu_bus (
    input  wire logic                   clk_sys,
    input  wire logic                   reset_n,

    // CPU memory bus
    input  wire logic                   mem_read,
    input  wire logic                   mem_write,
    input  wire m92_bus_pkg::cpu_addr_t mem_addr,
    input  wire m92_bus_pkg::lane_sel_t mem_sel,
    input  wire m92_bus_pkg::word_t     mem_wdata,
    output logic                        stall,
    output logic                        mem_done,
    output m92_bus_pkg::word_t          mem_rdata,

    // CPU I/O bus
    input  wire logic                   io_write,
    input  wire m92_bus_pkg::byte_t     io_addr,
    input  wire m92_bus_pkg::byte_t     io_data,

    output m92_bus_pkg::word_t          vid_ctrl,

    // SDRAM port
    output m92_bus_pkg::sdr_addr_t      sdr_addr,
    output m92_bus_pkg::word_t          sdr_din,
    output m92_bus_pkg::lane_sel_t      sdr_wr_sel,
    output logic                        sdr_req,
    input  wire logic                   sdr_rdy,
    input  wire m92_bus_pkg::word_t     sdr_dout
);

    logic strobe;
    logic busy;

    word_access_if   acc_if ();
    region_access_if dec_if ();

    assign strobe = mem_read | mem_write;
    assign stall  = busy;

    bus_capture capture0 (
        .clk_sys   (clk_sys),
        .reset_n   (reset_n),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_sel   (mem_sel),
        .mem_wdata (mem_wdata),
        .busy      (busy),
        .acc       (acc_if.capture)
    );

    region_decode decode0 (
        .clk_sys  (clk_sys),
        .reset_n  (reset_n),
        .acc      (acc_if.decode),
        .io_write (io_write),
        .io_addr  (io_addr),
        .io_data  (io_data),
        .vid_ctrl (vid_ctrl),
        .dec      (dec_if.decode)
    );

    sdram_request request0 (
        .clk_sys    (clk_sys),
        .reset_n    (reset_n),
        .dec        (dec_if.request),
        .strobe     (strobe),
        .sdr_addr   (sdr_addr),
        .sdr_din    (sdr_din),
        .sdr_wr_sel (sdr_wr_sel),
        .sdr_req    (sdr_req),
        .sdr_rdy    (sdr_rdy),
        .sdr_dout   (sdr_dout),
        .busy       (busy),
        .mem_done   (mem_done),
        .mem_rdata  (mem_rdata)
    );

endmodule

`default_nettype wire

// File: tb_sdram_model.sv
/*
 * Behavioral SDRAM responder
 * Answers each request after a pseudo random delay of 1 to 6
 * cycles. Writes honor the byte lane select.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_sdram_model (
    input  wire logic                   clk_sys,
    input  wire logic                   reset_n,
    input  wire m92_bus_pkg::sdr_addr_t sdr_addr,
    input  wire m92_bus_pkg::word_t     sdr_din,
    input  wire m92_bus_pkg::lane_sel_t sdr_wr_sel,
    input  wire logic                   sdr_req,
    output logic                        sdr_rdy,
    output m92_bus_pkg::word_t          sdr_dout
);

    m92_bus_pkg::word_t     mem [0:65535];    // Indexed by low address bits
    logic [31:0]            lcg_state;
    logic                   pending;
    int unsigned            wait_cnt;
    logic [15:0]            idx;
    m92_bus_pkg::word_t     din_q;
    m92_bus_pkg::lane_sel_t sel_q;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int unsigned pick_delay(input logic [31:0] s);
        return 1 + (s[31:16] % 6);
    endfunction

    always @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            sdr_rdy   <= 1'b0;
            sdr_dout  <= '0;
            pending   <= 1'b0;
            wait_cnt  <= 0;
            lcg_state <= 32'h254e99e4;
        end else begin
            sdr_rdy <= 1'b0;
            if (sdr_req) begin
                pending   <= 1'b1;
                idx       <= sdr_addr[15:0];
                din_q     <= sdr_din;
                sel_q     <= sdr_wr_sel;
                lcg_state <= lcg_next(lcg_state);
                wait_cnt  <= pick_delay(lcg_next(lcg_state));
            end else if (pending) begin
                if (wait_cnt == 1) begin
                    pending  <= 1'b0;
                    sdr_rdy  <= 1'b1;
                    sdr_dout <= mem[idx];    // Contents before any write
                    if (sel_q[0]) mem[idx][7:0]  <= din_q[7:0];
                    if (sel_q[1]) mem[idx][15:8] <= din_q[15:8];
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_m92_cpu_bus.sv
/*
 * Testbench for the M92 CPU bus bridge
 * Directed tests for lane alignment, region decode, bank switching
 * and local registers, against a behavioral SDRAM.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_m92_cpu_bus;

    localparam int CLK_PERIOD     = 10;
    localparam int NUM_TESTS      = 6;
    localparam int ACCESS_TIMEOUT = 50;    // Cycles to wait for mem_done

    logic                   clk_sys;
    logic                   reset_n;
    logic                   mem_read;
    logic                   mem_write;
    m92_bus_pkg::cpu_addr_t mem_addr;
    m92_bus_pkg::lane_sel_t mem_sel;
    m92_bus_pkg::word_t     mem_wdata;
    logic                   stall;
    logic                   mem_done;
    m92_bus_pkg::word_t     mem_rdata;
    logic                   io_write;
    m92_bus_pkg::byte_t     io_addr;
    m92_bus_pkg::byte_t     io_data;
    m92_bus_pkg::word_t     vid_ctrl;
    m92_bus_pkg::sdr_addr_t sdr_addr;
    m92_bus_pkg::word_t     sdr_din;
    m92_bus_pkg::lane_sel_t sdr_wr_sel;
    logic                   sdr_req;
    logic                   sdr_rdy;
    m92_bus_pkg::word_t     sdr_dout;

    // Results of the last access
    m92_bus_pkg::word_t     acc_rdata;
    int                     acc_cycles;
    int                     req_count;
    m92_bus_pkg::sdr_addr_t req_addr;
    m92_bus_pkg::lane_sel_t req_wr_sel;
    m92_bus_pkg::word_t     req_din;

    m92_cpu_bus dut0 (.*);

    tb_sdram_model sdram0 (
        .clk_sys(clk_sys), .reset_n(reset_n), .sdr_addr(sdr_addr), .sdr_din(sdr_din),
        .sdr_wr_sel(sdr_wr_sel), .sdr_req(sdr_req), .sdr_rdy(sdr_rdy), .sdr_dout(sdr_dout)
    );

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    // ==============================
    // Checking
    // ==============================
    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        abort_run();
    end

    // ==============================
    // Bus drivers
    // ==============================
    task automatic run_access(input logic wr, input m92_bus_pkg::cpu_addr_t addr,
                              input m92_bus_pkg::lane_sel_t sel, input m92_bus_pkg::word_t wdata);
        logic done_seen;
        done_seen  = 1'b0;
        acc_cycles = 0;
        req_count  = 0;
        @(posedge clk_sys);
        mem_read  <= ~wr;
        mem_write <= wr;
        mem_addr  <= addr;
        mem_sel   <= sel;
        mem_wdata <= wdata;
        @(posedge clk_sys);
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        while (!done_seen) begin
            @(negedge clk_sys);
            acc_cycles++;
            compare_value("stall", stall, 1'b1);    // High through the done cycle
            if (sdr_req) begin
                req_count++;
                req_addr   = sdr_addr;
                req_wr_sel = sdr_wr_sel;
                req_din    = sdr_din;
            end
            if (mem_done) begin
                done_seen = 1'b1;
                acc_rdata = mem_rdata;
            end else if (acc_cycles > ACCESS_TIMEOUT) begin
                $display("No mem_done within %0d cycles of a strobe", ACCESS_TIMEOUT);
                abort_run();
            end
        end
        @(negedge clk_sys);
        compare_value("stall", stall, 1'b0);
    endtask

    task automatic read_check(input m92_bus_pkg::cpu_addr_t addr,
                              input m92_bus_pkg::sdr_addr_t exp_addr,
                              input m92_bus_pkg::word_t stored);
        m92_bus_pkg::word_t expected;
        expected = addr[0] ? {8'h00, stored[15:8]} : stored;
        sdram0.mem[exp_addr[15:0]] = stored;
        run_access(1'b0, addr, addr[0] ? 2'b01 : 2'b11, 16'h0000);
        compare_value("sdr_req count", req_count, 1);
        compare_value("sdr_addr", req_addr, exp_addr);
        compare_value("sdr_wr_sel", req_wr_sel, 2'b00);
        compare_value("mem_rdata", acc_rdata, expected);
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic test_reset_state();
        @(negedge clk_sys);
        compare_value("stall", stall, 1'b0);
        compare_value("mem_done", mem_done, 1'b0);
        compare_value("sdr_req", sdr_req, 1'b0);
        compare_value("vid_ctrl", vid_ctrl, 16'h0000);
    endtask

    task automatic test_rom_ram_reads();
        read_check(20'h12344, 25'h0012344, 16'hA55A);
        read_check(20'h45679, 25'h0045678, 16'h3C96);    // Odd ROM byte
        read_check(20'hE1000, 25'h0201000, 16'h1357);
        read_check(20'hE2223, 25'h0202222, 16'h8E41);
    endtask

    task automatic test_ram_writes();
        sdram0.mem[16'h3000] = 16'h1234;
        run_access(1'b1, 20'hE3001, 2'b01, 16'h00AB);
        compare_value("sdr_addr", req_addr, 25'h0203000);
        compare_value("sdr_wr_sel", req_wr_sel, 2'b10);
        compare_value("sdr_din upper byte", req_din[15:8], 8'hAB);
        compare_value("RAM contents", sdram0.mem[16'h3000], 16'hAB34);    // Low byte kept
        read_check(20'hE3000, 25'h0203000, 16'hAB34);
    endtask

    task automatic test_rom_write();
        sdram0.mem[16'h5000] = 16'hC0DE;
        run_access(1'b1, 20'h05000, 2'b11, 16'hDEAD);
        compare_value("sdr_req count", req_count, 1);
        compare_value("sdr_wr_sel", req_wr_sel, 2'b00);    // Issued as a read
        compare_value("ROM contents", sdram0.mem[16'h5000], 16'hC0DE);
    endtask

    task automatic test_bank_switch();
        @(posedge clk_sys);
        io_write <= 1'b1;
        io_addr  <= 8'h20;
        io_data  <= 8'h03;
        @(posedge clk_sys);
        io_write <= 1'b0;
        read_check(20'hA0010, m92_bus_pkg::BANK_SDR_BASE + 25'd3 * 25'h20000 + 25'h10, 16'hBEEF);
    endtask

    task automatic test_local_unmapped();
        run_access(1'b1, m92_bus_pkg::VID_CTRL_ADDR, 2'b11, 16'h5A3C);
        compare_value("sdr_req count", req_count, 0);
        compare_value("vid_ctrl", vid_ctrl, 16'h5A3C);
        run_access(1'b0, m92_bus_pkg::VID_CTRL_ADDR, 2'b11, 16'h0000);
        compare_value("mem_rdata", acc_rdata, 16'h5A3C);
        compare_value("mem_done cycle", acc_cycles, 3);
        compare_value("sdr_req count", req_count, 0);
        run_access(1'b0, 20'hC0000, 2'b11, 16'h0000);    // Gap between bank and RAM
        compare_value("mem_rdata", acc_rdata, 16'hFFFF);
        compare_value("sdr_req count", req_count, 0);
    endtask

    initial begin
        reset_n   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        mem_addr  = '0;
        mem_sel   = '0;
        mem_wdata = '0;
        io_write  = 1'b0;
        io_addr   = '0;
        io_data   = '0;
        repeat (16) @(posedge clk_sys);
        reset_n <= 1'b1;
        test_reset_state();
        test_rom_ram_reads();
        test_ram_writes();
        test_rom_write();
        test_bank_switch();
        test_local_unmapped();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
m92_bus_pkg.sv
word_access_if.sv
region_access_if.sv
bus_capture.sv
region_decode.sv
sdram_request.sv
m92_cpu_bus.sv
tb_sdram_model.sv
tb_m92_cpu_bus.sv
